//--- Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = axil_ram_tb
LINT_TOP  = axil_ram_subsys
FILE_LIST = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = STATUS: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
verilog/axil_ram_pkg.sv
verilog/axil_ram.sv
verilog/axil_arbiter.sv
verilog/fill_engine.sv
verilog/axil_ram_subsys.sv
tb/axil_ram_tb.sv

//--- tb/axil_ram_tb.sv
`timescale 1ns/1ps

module axil_ram_tb;

    localparam int HS_LIMIT   = 200;   // cycles per handshake wait
    localparam int FILL_LIMIT = 4000;  // cycles for a whole fill

    logic clk;
    logic rst;

    axil_ram_pkg::axil_req_t host_req;
    axil_ram_pkg::axil_rsp_t host_rsp;

    logic                 fill_start;
    axil_ram_pkg::addr_t  fill_base;
    axil_ram_pkg::count_t fill_count;
    axil_ram_pkg::data_t  fill_pattern;
    logic                 fill_busy;
    logic                 fill_done;
    logic                 fill_error;
    logic                 pause_req;
    logic                 pause_ack;

    axil_ram_pkg::data_t model [axil_ram_pkg::RAM_WORDS];  // expected RAM contents

    int mismatches;
    int failures;

    axil_ram_subsys axil_ram_subsys_i (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .fill_start   (fill_start),
        .fill_base    (fill_base),
        .fill_count   (fill_count),
        .fill_pattern (fill_pattern),
        .fill_busy    (fill_busy),
        .fill_done    (fill_done),
        .fill_error   (fill_error),
        .pause_req    (pause_req),
        .pause_ack    (pause_ack)
    );

    always #50 clk = ~clk;

    task automatic check_data(input string name, input axil_ram_pkg::data_t got,
                              input axil_ram_pkg::data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_resp(input string name, input axil_ram_pkg::resp_t got,
                              input axil_ram_pkg::resp_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        failures++;
    endtask

    // aligned and inside the RAM
    function automatic logic decodes_ok(input axil_ram_pkg::addr_t a);
        return (a[1:0] == 2'b00) && (int'(a) < axil_ram_pkg::RAM_BYTES);
    endfunction

    function automatic axil_ram_pkg::index_t word_index(input axil_ram_pkg::addr_t a);
        return a[axil_ram_pkg::OFFSET_BITS +: axil_ram_pkg::INDEX_BITS];
    endfunction

    function automatic axil_ram_pkg::data_t merge_lanes(input axil_ram_pkg::data_t old_word,
                                                        input axil_ram_pkg::data_t new_word,
                                                        input axil_ram_pkg::strb_t s);
        axil_ram_pkg::data_t w;
        w = old_word;
        for (int i = 0; i < axil_ram_pkg::STRB_WIDTH; i++) begin
            if (s[i]) w[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return w;
    endfunction

    task automatic write_issue(input axil_ram_pkg::addr_t a, input axil_ram_pkg::data_t d,
                               input axil_ram_pkg::strb_t s);
        @(posedge clk);
        host_req.aw_valid <= 1'b1;
        host_req.aw_addr  <= a;
        host_req.w_valid  <= 1'b1;
        host_req.w_data   <= d;
        host_req.w_strb   <= s;
        host_req.b_ready  <= 1'b1;
    endtask

    task automatic write_finish(output axil_ram_pkg::resp_t resp);
        int   t;
        logic aw_sent;
        logic w_sent;
        t = 0;
        aw_sent = 1'b0;
        w_sent = 1'b0;
        resp = 'x;
        while (!(aw_sent && w_sent) && t < HS_LIMIT) begin
            @(negedge clk);
            if (host_req.aw_valid && host_rsp.aw_ready) aw_sent = 1'b1;
            if (host_req.w_valid && host_rsp.w_ready) w_sent = 1'b1;
            @(posedge clk);  // transfer happens on this edge
            if (aw_sent) host_req.aw_valid <= 1'b0;
            if (w_sent) host_req.w_valid <= 1'b0;
            t++;
        end
        if (!(aw_sent && w_sent)) note_failure("timeout waiting for write address or data");
        t = 0;
        @(negedge clk);
        while (!host_rsp.b_valid && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (host_rsp.b_valid) resp = host_rsp.b_resp;
        else note_failure("timeout waiting for write response");
        @(posedge clk);
        host_req.aw_valid <= 1'b0;
        host_req.w_valid  <= 1'b0;
        host_req.b_ready  <= 1'b0;
    endtask

    task automatic host_read(input axil_ram_pkg::addr_t a, output axil_ram_pkg::data_t d,
                             output axil_ram_pkg::resp_t resp);
        int   t;
        logic ar_sent;
        t = 0;
        ar_sent = 1'b0;
        d = 'x;
        resp = 'x;
        @(posedge clk);
        host_req.ar_valid <= 1'b1;
        host_req.ar_addr  <= a;
        host_req.r_ready  <= 1'b1;
        while (!ar_sent && t < HS_LIMIT) begin
            @(negedge clk);
            if (host_req.ar_valid && host_rsp.ar_ready) ar_sent = 1'b1;
            @(posedge clk);
            if (ar_sent) host_req.ar_valid <= 1'b0;
            t++;
        end
        if (!ar_sent) note_failure("timeout waiting for read address accept");
        t = 0;
        @(negedge clk);
        while (!host_rsp.r_valid && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (host_rsp.r_valid) begin
            d = host_rsp.r_data;
            resp = host_rsp.r_resp;
        end else begin
            note_failure("timeout waiting for read data");
        end
        @(posedge clk);
        host_req.ar_valid <= 1'b0;
        host_req.r_ready  <= 1'b0;
    endtask

    task automatic write_expect(input axil_ram_pkg::addr_t a, input axil_ram_pkg::data_t d,
                                input axil_ram_pkg::strb_t s);
        axil_ram_pkg::resp_t r;
        axil_ram_pkg::resp_t exp_r;
        exp_r = decodes_ok(a) ? axil_ram_pkg::RESP_OKAY : axil_ram_pkg::RESP_DECERR;
        write_issue(a, d, s);
        write_finish(r);
        check_resp($sformatf("b_resp[%h]", a), r, exp_r);
        if (exp_r == axil_ram_pkg::RESP_OKAY) begin
            model[word_index(a)] = merge_lanes(model[word_index(a)], d, s);
        end
    endtask

    task automatic read_expect(input axil_ram_pkg::addr_t a);
        axil_ram_pkg::data_t d;
        axil_ram_pkg::resp_t r;
        host_read(a, d, r);
        if (decodes_ok(a)) begin
            check_resp($sformatf("r_resp[%h]", a), r, axil_ram_pkg::RESP_OKAY);
            check_data($sformatf("r_data[%h]", a), d, model[word_index(a)]);
        end else begin
            check_resp($sformatf("r_resp[%h]", a), r, axil_ram_pkg::RESP_DECERR);
            check_data($sformatf("r_data[%h]", a), d, '0);
        end
    endtask

    task automatic start_fill(input axil_ram_pkg::addr_t base, input axil_ram_pkg::count_t n,
                              input axil_ram_pkg::data_t pat);
        @(posedge clk);
        fill_base    <= base;
        fill_count   <= n;
        fill_pattern <= pat;
        fill_start   <= 1'b1;
        @(posedge clk);
        fill_start   <= 1'b0;
        @(negedge clk);
        check_flag("fill_busy", fill_busy, n != '0);  // busy from the cycle after start
    endtask

    task automatic wait_fill_done(input logic exp_err);
        int t;
        t = 0;
        @(negedge clk);
        while (!fill_done && t < FILL_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!fill_done) begin
            note_failure("timeout waiting for fill_done");
        end else begin
            check_flag("fill_busy", fill_busy, 1'b0);
            check_flag("fill_error", fill_error, exp_err);
        end
    endtask

    // word i gets pattern plus i unless past the end
    task automatic apply_fill(input axil_ram_pkg::addr_t base, input axil_ram_pkg::count_t n,
                              input axil_ram_pkg::data_t pat);
        axil_ram_pkg::addr_t a;
        for (int i = 0; i < int'(n); i++) begin
            a = base + axil_ram_pkg::addr_t'(i * 4);
            if (decodes_ok(a)) model[word_index(a)] = pat + axil_ram_pkg::data_t'(i);
        end
    endtask

    task automatic readback_region(input axil_ram_pkg::addr_t base, input int n);
        axil_ram_pkg::addr_t a;
        for (int i = 0; i < n; i++) begin
            a = base + axil_ram_pkg::addr_t'(i * 4);
            if (decodes_ok(a)) read_expect(a);
        end
    endtask

    task automatic strobe_writes();
        axil_ram_pkg::strb_t strobes [3];
        axil_ram_pkg::addr_t a;
        strobes[0] = 4'b0011;
        strobes[1] = 4'b1000;
        strobes[2] = 4'b0101;
        for (int n = 0; n < 4; n++) begin
            a = axil_ram_pkg::addr_t'(($urandom % axil_ram_pkg::RAM_WORDS) * 4);
            write_expect(a, $urandom, 4'hf);
            read_expect(a);
            for (int j = 0; j < 3; j++) begin
                write_expect(a, $urandom, strobes[j]);
                read_expect(a);
            end
        end
    endtask

    task automatic decode_errors();
        write_expect(16'h0100, $urandom, 4'hf);
        write_expect(16'h0102, $urandom, 4'hf);  // misaligned
        write_expect(16'h1100, $urandom, 4'hf);  // would alias 0x100 if wrapped
        write_expect(16'hfffc, $urandom, 4'hf);
        read_expect(16'h0100);
        read_expect(16'h0102);
        read_expect(16'h1100);
        read_expect(axil_ram_pkg::addr_t'(axil_ram_pkg::RAM_BYTES));
    endtask

    task automatic plain_fill();
        axil_ram_pkg::data_t pat;
        pat = $urandom;
        start_fill(16'h0200, 11'd16, pat);
        wait_fill_done(1'b0);
        apply_fill(16'h0200, 11'd16, pat);
        readback_region(16'h0200, 16);
    endtask

    task automatic shared_access();
        axil_ram_pkg::data_t pat;
        pat = $urandom;
        start_fill(16'h0400, 11'd32, pat);
        fork
            wait_fill_done(1'b0);
            begin
                for (int i = 0; i < 6; i++) begin
                    write_expect(axil_ram_pkg::addr_t'(16'h0800 + i * 4), $urandom, 4'hf);
                    read_expect(axil_ram_pkg::addr_t'(16'h0800 + i * 4));
                end
            end
        join
        apply_fill(16'h0400, 11'd32, pat);
        readback_region(16'h0400, 32);
        readback_region(16'h0800, 6);
    endtask

    task automatic pause_hold();
        axil_ram_pkg::data_t d;
        axil_ram_pkg::resp_t r;
        int                  t;
        d = $urandom;
        t = 0;
        @(posedge clk);
        pause_req <= 1'b1;
        @(negedge clk);
        while (!pause_ack && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!pause_ack) note_failure("timeout waiting for pause_ack");
        write_issue(16'h0c00, d, 4'hf);
        repeat (20) begin
            @(negedge clk);
            check_flag("b_valid", host_rsp.b_valid, 1'b0);  // held off while paused
            check_flag("pause_ack", pause_ack, 1'b1);
        end
        @(posedge clk);
        pause_req <= 1'b0;
        write_finish(r);
        check_resp("b_resp[0c00]", r, axil_ram_pkg::RESP_OKAY);
        model[word_index(16'h0c00)] = d;
        check_flag("pause_ack", pause_ack, 1'b0);
        read_expect(16'h0c00);
    endtask

    task automatic fill_overrun();
        axil_ram_pkg::data_t pat;
        pat = $urandom;
        start_fill(16'h0ff0, 11'd8, pat);  // last 4 words fall past the end
        wait_fill_done(1'b1);
        apply_fill(16'h0ff0, 11'd8, pat);
        readback_region(16'h0ff0, 8);
    endtask

    initial begin
        void'($urandom(32'hf617));
        clk = 1'b0;
        rst = 1'b1;
        host_req = '0;
        fill_start = 1'b0;
        fill_base = '0;
        fill_count = '0;
        fill_pattern = '0;
        pause_req = 1'b0;
        mismatches = 0;
        failures = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("fill_busy", fill_busy, 1'b0);
        check_flag("fill_done", fill_done, 1'b0);
        check_flag("fill_error", fill_error, 1'b0);
        check_flag("pause_ack", pause_ack, 1'b0);

        strobe_writes();
        decode_errors();
        plain_fill();
        shared_access();
        pause_hold();
        fill_overrun();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/axil_arbiter.sv
`timescale 1ns/1ps

module axil_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  axil_ram_pkg::axil_req_t m0_req,
    output axil_ram_pkg::axil_rsp_t m0_rsp,
    input  axil_ram_pkg::axil_req_t m1_req,
    output axil_ram_pkg::axil_rsp_t m1_rsp,
    output axil_ram_pkg::axil_req_t s_req,
    input  axil_ram_pkg::axil_rsp_t s_rsp
);

    axil_ram_pkg::arb_state_e state;
    axil_ram_pkg::arb_state_e next_state;

    logic last_m1;  // master granted most recently

    logic m0_wr;
    logic m0_rd;
    logic m1_wr;
    logic m1_rd;
    logic grant_m1;
    logic grant_wr;
    logic grant_rd;
    logic wr_done;
    logic rd_done;

    axil_ram_pkg::axil_req_t sel_req;
    axil_ram_pkg::axil_rsp_t sel_rsp;

    assign m0_wr = m0_req.aw_valid || m0_req.w_valid;
    assign m0_rd = m0_req.ar_valid;
    assign m1_wr = m1_req.aw_valid || m1_req.w_valid;
    assign m1_rd = m1_req.ar_valid;

    assign grant_m1 = (state == axil_ram_pkg::ARB_M1_WR) || (state == axil_ram_pkg::ARB_M1_RD);
    assign grant_wr = (state == axil_ram_pkg::ARB_M0_WR) || (state == axil_ram_pkg::ARB_M1_WR);
    assign grant_rd = (state == axil_ram_pkg::ARB_M0_RD) || (state == axil_ram_pkg::ARB_M1_RD);

    assign sel_req = grant_m1 ? m1_req : m0_req;

    // only the granted direction reaches the RAM
    always_comb begin
        s_req   = sel_req;
        sel_rsp = s_rsp;
        if (!grant_wr) begin
            s_req.aw_valid   = 1'b0;
            s_req.w_valid    = 1'b0;
            s_req.b_ready    = 1'b0;
            sel_rsp.aw_ready = 1'b0;
            sel_rsp.w_ready  = 1'b0;
            sel_rsp.b_valid  = 1'b0;
        end
        if (!grant_rd) begin
            s_req.ar_valid   = 1'b0;
            s_req.r_ready    = 1'b0;
            sel_rsp.ar_ready = 1'b0;
            sel_rsp.r_valid  = 1'b0;
        end
        m0_rsp = '0;
        m1_rsp = '0;
        if (grant_m1) begin
            m1_rsp = sel_rsp;
        end else begin
            m0_rsp = sel_rsp;
        end
    end

    assign wr_done = s_rsp.b_valid && s_req.b_ready;
    assign rd_done = s_rsp.r_valid && s_req.r_ready;

    always_comb begin
        next_state = state;
        case (state)
            axil_ram_pkg::ARB_IDLE: begin
                if (last_m1) begin  // m0 goes first
                    if (m0_wr) next_state = axil_ram_pkg::ARB_M0_WR;
                    else if (m0_rd) next_state = axil_ram_pkg::ARB_M0_RD;
                    else if (m1_wr) next_state = axil_ram_pkg::ARB_M1_WR;
                    else if (m1_rd) next_state = axil_ram_pkg::ARB_M1_RD;
                end else begin
                    if (m1_wr) next_state = axil_ram_pkg::ARB_M1_WR;
                    else if (m1_rd) next_state = axil_ram_pkg::ARB_M1_RD;
                    else if (m0_wr) next_state = axil_ram_pkg::ARB_M0_WR;
                    else if (m0_rd) next_state = axil_ram_pkg::ARB_M0_RD;
                end
            end
            axil_ram_pkg::ARB_M0_WR,
            axil_ram_pkg::ARB_M1_WR: begin
                if (wr_done) next_state = axil_ram_pkg::ARB_IDLE;
            end
            axil_ram_pkg::ARB_M0_RD,
            axil_ram_pkg::ARB_M1_RD: begin
                if (rd_done) next_state = axil_ram_pkg::ARB_IDLE;
            end
            default: next_state = axil_ram_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= axil_ram_pkg::ARB_IDLE;
            last_m1 <= 1'b1;  // host wins the first tie
        end else begin
            state <= next_state;
            if (state == axil_ram_pkg::ARB_IDLE && next_state != axil_ram_pkg::ARB_IDLE) begin
                last_m1 <= (next_state == axil_ram_pkg::ARB_M1_WR) ||
                           (next_state == axil_ram_pkg::ARB_M1_RD);
            end
        end
    end

endmodule

//--- verilog/axil_ram.sv
`timescale 1ns/1ps

module axil_ram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pause_req,
    output logic                    pause_ack,
    input  axil_ram_pkg::axil_req_t req,
    output axil_ram_pkg::axil_rsp_t rsp
);

    axil_ram_pkg::data_t mem [axil_ram_pkg::RAM_WORDS];

    axil_ram_pkg::addr_t waddr;
    axil_ram_pkg::data_t wdata;
    axil_ram_pkg::strb_t wstrb;
    axil_ram_pkg::addr_t raddr;

    logic aw_pend;
    logic w_pend;
    logic ar_pend;
    logic b_valid;
    logic r_valid;

    axil_ram_pkg::resp_t b_resp;
    axil_ram_pkg::resp_t r_resp;
    axil_ram_pkg::data_t r_data;

    logic idle;
    logic stall;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic write_go;
    logic read_go;

    axil_ram_pkg::addr_t  cur_waddr;
    axil_ram_pkg::data_t  cur_wdata;
    axil_ram_pkg::strb_t  cur_wstrb;
    axil_ram_pkg::addr_t  cur_raddr;
    axil_ram_pkg::index_t widx;
    axil_ram_pkg::index_t ridx;

    function automatic logic addr_ok(input axil_ram_pkg::addr_t a);
        return (a[axil_ram_pkg::OFFSET_BITS-1:0] == '0) &&
               (a < axil_ram_pkg::addr_t'(axil_ram_pkg::RAM_BYTES));
    endfunction

    assign idle  = !aw_pend && !w_pend && !ar_pend && !b_valid && !r_valid;
    assign stall = pause_ack || (pause_req && idle);  // no new work while pausing

    always_comb begin
        rsp.aw_ready = !aw_pend && !b_valid && !r_valid && !stall;
        rsp.w_ready  = !w_pend && !b_valid && !r_valid && !stall;
        rsp.b_valid  = b_valid;
        rsp.b_resp   = b_resp;
        rsp.ar_ready = !ar_pend && !b_valid && !r_valid && !stall;
        rsp.r_valid  = r_valid;
        rsp.r_data   = r_data;
        rsp.r_resp   = r_resp;
    end

    assign aw_hs = req.aw_valid && rsp.aw_ready;
    assign w_hs  = req.w_valid && rsp.w_ready;
    assign ar_hs = req.ar_valid && rsp.ar_ready;

    // captured value, or the one arriving this cycle
    assign cur_waddr = aw_pend ? waddr : req.aw_addr;
    assign cur_wdata = w_pend ? wdata : req.w_data;
    assign cur_wstrb = w_pend ? wstrb : req.w_strb;
    assign cur_raddr = ar_pend ? raddr : req.ar_addr;

    assign widx = cur_waddr[axil_ram_pkg::OFFSET_BITS +: axil_ram_pkg::INDEX_BITS];
    assign ridx = cur_raddr[axil_ram_pkg::OFFSET_BITS +: axil_ram_pkg::INDEX_BITS];

    // write wins when both are ready to go
    assign write_go = (aw_pend || aw_hs) && (w_pend || w_hs) && !b_valid && !r_valid;
    assign read_go  = (ar_pend || ar_hs) && !write_go && !b_valid && !r_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_pend   <= 1'b0;
            w_pend    <= 1'b0;
            ar_pend   <= 1'b0;
            b_valid   <= 1'b0;
            r_valid   <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && idle;

            if (aw_hs) aw_pend <= 1'b1;
            if (w_hs) w_pend <= 1'b1;
            if (ar_hs) ar_pend <= 1'b1;

            if (b_valid && req.b_ready) b_valid <= 1'b0;
            if (r_valid && req.r_ready) r_valid <= 1'b0;

            if (write_go) begin
                aw_pend <= 1'b0;
                w_pend  <= 1'b0;
                b_valid <= 1'b1;
            end
            if (read_go) begin
                ar_pend <= 1'b0;
                r_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) waddr <= req.aw_addr;
        if (w_hs) begin
            wdata <= req.w_data;
            wstrb <= req.w_strb;
        end
        if (ar_hs) raddr <= req.ar_addr;

        if (write_go) begin
            if (addr_ok(cur_waddr)) begin
                for (int i = 0; i < axil_ram_pkg::STRB_WIDTH; i++) begin
                    if (cur_wstrb[i]) mem[widx][i*8 +: 8] <= cur_wdata[i*8 +: 8];
                end
                b_resp <= axil_ram_pkg::RESP_OKAY;
            end else begin
                b_resp <= axil_ram_pkg::RESP_DECERR;  // memory untouched
            end
        end

        if (read_go) begin
            if (addr_ok(cur_raddr)) begin
                r_data <= mem[ridx];
                r_resp <= axil_ram_pkg::RESP_OKAY;
            end else begin
                r_data <= '0;
                r_resp <= axil_ram_pkg::RESP_DECERR;
            end
        end
    end

endmodule

//--- verilog/axil_ram_pkg.sv
package axil_ram_pkg;

    localparam int ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int RAM_BYTES   = 4096;
    localparam int RAM_WORDS   = RAM_BYTES / STRB_WIDTH;
    localparam int OFFSET_BITS = $clog2(STRB_WIDTH);  // byte offset inside a word
    localparam int INDEX_BITS  = $clog2(RAM_WORDS);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [1:0]            resp_t;
    typedef logic [INDEX_BITS:0]   count_t;  // 0 to RAM_WORDS inclusive

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // master to slave
    typedef struct packed {
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  b_ready;
        logic  ar_valid;
        addr_t ar_addr;
        logic  r_ready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
        resp_t b_resp;
        logic  ar_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
    } axil_rsp_t;

    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_M0_WR,
        ARB_M0_RD,
        ARB_M1_WR,
        ARB_M1_RD
    } arb_state_e;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR_DATA,
        FILL_RESP,
        FILL_DONE
    } fill_state_e;

endpackage

//--- verilog/axil_ram_subsys.sv
`timescale 1ns/1ps

module axil_ram_subsys (
    input  logic                    clk,
    input  logic                    rst,
    input  axil_ram_pkg::axil_req_t host_req,
    output axil_ram_pkg::axil_rsp_t host_rsp,
    input  logic                    fill_start,
    input  axil_ram_pkg::addr_t     fill_base,
    input  axil_ram_pkg::count_t    fill_count,
    input  axil_ram_pkg::data_t     fill_pattern,
    output logic                    fill_busy,
    output logic                    fill_done,
    output logic                    fill_error,
    input  logic                    pause_req,
    output logic                    pause_ack
);

    axil_ram_pkg::axil_req_t fill_req;
    axil_ram_pkg::axil_rsp_t fill_rsp;
    axil_ram_pkg::axil_req_t ram_req;
    axil_ram_pkg::axil_rsp_t ram_rsp;

    fill_engine fill_engine_i (
        .clk          (clk),
        .rst          (rst),
        .fill_start   (fill_start),
        .fill_base    (fill_base),
        .fill_count   (fill_count),
        .fill_pattern (fill_pattern),
        .fill_busy    (fill_busy),
        .fill_done    (fill_done),
        .fill_error   (fill_error),
        .req          (fill_req),
        .rsp          (fill_rsp)
    );

    // host on m0, fill on m1
    axil_arbiter axil_arbiter_i (
        .clk    (clk),
        .rst    (rst),
        .m0_req (host_req),
        .m0_rsp (host_rsp),
        .m1_req (fill_req),
        .m1_rsp (fill_rsp),
        .s_req  (ram_req),
        .s_rsp  (ram_rsp)
    );

    axil_ram axil_ram_i (
        .clk       (clk),
        .rst       (rst),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .req       (ram_req),
        .rsp       (ram_rsp)
    );

endmodule

//--- verilog/fill_engine.sv
`timescale 1ns/1ps

module fill_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fill_start,
    input  axil_ram_pkg::addr_t     fill_base,
    input  axil_ram_pkg::count_t    fill_count,
    input  axil_ram_pkg::data_t     fill_pattern,
    output logic                    fill_busy,
    output logic                    fill_done,
    output logic                    fill_error,
    output axil_ram_pkg::axil_req_t req,
    input  axil_ram_pkg::axil_rsp_t rsp
);

    axil_ram_pkg::fill_state_e state;

    axil_ram_pkg::addr_t  base_q;
    axil_ram_pkg::count_t count_q;
    axil_ram_pkg::data_t  pattern_q;
    axil_ram_pkg::count_t index;
    axil_ram_pkg::count_t index_next;

    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic error_q;

    always_comb begin
        req.aw_valid = (state == axil_ram_pkg::FILL_ADDR_DATA) && !aw_done;
        req.aw_addr  = base_q +
                       axil_ram_pkg::addr_t'({index, {axil_ram_pkg::OFFSET_BITS{1'b0}}});
        req.w_valid  = (state == axil_ram_pkg::FILL_ADDR_DATA) && !w_done;
        req.w_data   = pattern_q + axil_ram_pkg::data_t'(index);
        req.w_strb   = '1;
        req.b_ready  = (state == axil_ram_pkg::FILL_RESP);
        req.ar_valid = 1'b0;  // write-only master
        req.ar_addr  = '0;
        req.r_ready  = 1'b0;
    end

    assign aw_hs      = req.aw_valid && rsp.aw_ready;
    assign w_hs       = req.w_valid && rsp.w_ready;
    assign b_hs       = req.b_ready && rsp.b_valid;
    assign index_next = index + 1'b1;

    assign fill_busy  = (state == axil_ram_pkg::FILL_ADDR_DATA) ||
                        (state == axil_ram_pkg::FILL_RESP);
    assign fill_done  = (state == axil_ram_pkg::FILL_DONE);
    assign fill_error = error_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= axil_ram_pkg::FILL_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            case (state)
                axil_ram_pkg::FILL_IDLE: begin
                    if (fill_start) begin
                        error_q <= 1'b0;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= (fill_count == '0) ? axil_ram_pkg::FILL_DONE
                                                      : axil_ram_pkg::FILL_ADDR_DATA;
                    end
                end
                axil_ram_pkg::FILL_ADDR_DATA: begin
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= axil_ram_pkg::FILL_RESP;
                    end else begin
                        if (aw_hs) aw_done <= 1'b1;
                        if (w_hs) w_done <= 1'b1;
                    end
                end
                axil_ram_pkg::FILL_RESP: begin
                    if (b_hs) begin
                        if (rsp.b_resp == axil_ram_pkg::RESP_DECERR) error_q <= 1'b1;
                        state <= (index_next == count_q) ? axil_ram_pkg::FILL_DONE
                                                         : axil_ram_pkg::FILL_ADDR_DATA;
                    end
                end
                default: state <= axil_ram_pkg::FILL_IDLE;  // one-cycle done
            endcase
        end
    end

    // job parameters and word index
    always_ff @(posedge clk) begin
        if (state == axil_ram_pkg::FILL_IDLE && fill_start) begin
            base_q    <= fill_base;
            count_q   <= fill_count;
            pattern_q <= fill_pattern;
            index     <= '0;
        end else if (state == axil_ram_pkg::FILL_RESP && b_hs) begin
            index <= index_next;
        end
    end

endmodule
